/* fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'haaaaa000

// instruction queue entries, power of two
`define IQ_DEPTH 16

// 64-bit memory beats that make one 256-bit line
`define BEATS_PER_LINE 4

`endif

/* fetch_pkg.sv */
package fetch_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // dynamic instruction sequence number
    typedef logic [63:0] order_t;

    // one memory data beat
    typedef logic [63:0] beat_t;

    // eight instructions, one cache line
    typedef logic [255:0] line_t;

    // line address, upper 27 address bits
    typedef logic [26:0] line_tag_t;

    // instruction index inside a line
    typedef logic [2:0] word_sel_t;

    // fetch controller states
    typedef enum logic [1:0] {
        RUN,
        FILL,
        DISCARD
    } fetch_state_t;

endpackage

/* burst_assembler.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module burst_assembler
import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      fill_req_i,
    input  line_tag_t fill_addr_i,
    input  beat_t     bmem_rdata_i,
    input  logic      bmem_rvalid_i,
    output addr_t     bmem_addr_o,
    output logic      bmem_read_o,
    output logic      fill_done_o,
    output line_t     fill_line_o
);

    localparam int CNT_W = $clog2(`BEATS_PER_LINE);

    logic             busy;
    logic [CNT_W-1:0] beat_cnt;
    logic             last_beat;

    assign last_beat = bmem_rvalid_i && (beat_cnt == CNT_W'(`BEATS_PER_LINE - 1));

    // burst control
    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            beat_cnt    <= '0;
            bmem_read_o <= 1'b0;
            fill_done_o <= 1'b0;
        end else begin
            bmem_read_o <= fill_req_i;
            fill_done_o <= busy && last_beat;
            if (fill_req_i && !busy) begin
                busy     <= 1'b1;
                beat_cnt <= '0;
            end else if (busy && bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // line address and beat data
    always_ff @(posedge clk) begin
        if (fill_req_i && !busy) begin
            bmem_addr_o <= {fill_addr_i, 5'b00000};
        end
        if (busy && bmem_rvalid_i) begin
            // beats arrive lowest address first
            fill_line_o[beat_cnt * $bits(beat_t) +: $bits(beat_t)] <= bmem_rdata_i;
        end
    end

    // the controller must wait for fill_done before asking again
    a_no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        fill_req_i |-> !busy);

    a_read_one_cycle: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |=> !bmem_read_o);

endmodule

/* line_buffer.sv */
`timescale 1ns/1ps

module line_buffer
import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load_i,
    input  line_tag_t load_tag_i,
    input  line_t     load_line_i,
    input  logic      invalidate_i,
    input  addr_t     pc_i,
    output logic      hit_o,
    output inst_t     word_o
);

    logic      valid_q;
    line_tag_t tag_q;
    line_t     line_q;
    word_sel_t sel;

    // invalidate beats a load in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (invalidate_i) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            tag_q  <= load_tag_i;
            line_q <= load_line_i;
        end
    end

    // pc[4:2] picks the word, pc[31:5] must match the tag
    assign sel    = pc_i[4:2];
    assign hit_o  = valid_q && (tag_q == pc_i[31:5]);
    assign word_o = line_q[sel * $bits(inst_t) +: $bits(inst_t)];

endmodule

/* inst_queue.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module inst_queue
import fetch_pkg::*;
#(
    parameter int DEPTH = `IQ_DEPTH
)
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush_i,
    input  logic   enq_i,
    input  inst_t  enq_inst_i,
    input  addr_t  enq_pc_i,
    input  order_t enq_order_i,
    input  logic   deq_i,
    output logic   full_o,
    output logic   valid_o,
    output inst_t  inst_o,
    output addr_t  pc_o,
    output order_t order_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    inst_t  inst_mem  [DEPTH];
    addr_t  pc_mem    [DEPTH];
    order_t order_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq_i, deq_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (enq_i) begin
            inst_mem[wr_ptr]  <= enq_inst_i;
            pc_mem[wr_ptr]    <= enq_pc_i;
            order_mem[wr_ptr] <= enq_order_i;
        end
    end

    assign full_o  = (count == CNT_W'(DEPTH));
    assign valid_o = (count != '0);

    // head shown without a register stage
    assign inst_o  = inst_mem[rd_ptr];
    assign pc_o    = pc_mem[rd_ptr];
    assign order_o = order_mem[rd_ptr];

    a_no_enq_full: assert property (@(posedge clk) disable iff (rst || flush_i)
        enq_i |-> !full_o);

    a_no_deq_empty: assert property (@(posedge clk) disable iff (rst || flush_i)
        deq_i |-> valid_o);

endmodule

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_ctrl
import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      redirect_i,
    input  addr_t     redirect_pc_i,
    input  logic      hit_i,
    input  inst_t     word_i,
    input  logic      fill_done_i,
    input  logic      full_i,
    output addr_t     pc_o,
    output logic      fill_req_o,
    output line_tag_t fill_addr_o,
    output logic      invalidate_o,
    output logic      enq_o,
    output inst_t     enq_inst_o,
    output addr_t     enq_pc_o,
    output order_t    enq_order_o
);

    fetch_state_t state;
    fetch_state_t state_next;
    addr_t        pc;
    order_t       order;

    // hits stream one per cycle unless the queue is full or commit redirects
    assign enq_o       = (state == RUN) && hit_i && !full_i && !redirect_i;
    assign enq_inst_o  = word_i;
    assign enq_pc_o    = pc;
    assign enq_order_o = order;

    // miss in RUN asks for the line holding pc
    assign fill_req_o  = (state == RUN) && !hit_i && !redirect_i;
    assign fill_addr_o = pc[31:5];

    // the buffered line may belong to the old path
    assign invalidate_o = redirect_i;

    assign pc_o = pc;

    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                if (fill_req_o) begin
                    state_next = FILL;
                end
            end
            FILL: begin
                // a redirect with fill_done still ends the burst
                if (fill_done_i) begin
                    state_next = RUN;
                end else if (redirect_i) begin
                    state_next = DISCARD;
                end
            end
            DISCARD: begin
                if (fill_done_i) begin
                    state_next = RUN;
                end
            end
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN;
            pc    <= `FETCH_RESET_PC;
            order <= '0;
        end else begin
            state <= state_next;
            if (redirect_i) begin
                // order keeps counting across a redirect
                pc <= redirect_pc_i;
            end else if (enq_o) begin
                pc    <= pc + 32'd4;
                order <= order + 64'd1;
            end
        end
    end

    // burst assembler only finishes a fill that was requested
    a_done_only_waiting: assert property (@(posedge clk) disable iff (rst)
        fill_done_i |-> (state != RUN));

endmodule

/* fetch_frontend.sv */
`timescale 1ns/1ps

module fetch_frontend
import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    output addr_t  bmem_addr_o,
    output logic   bmem_read_o,
    input  beat_t  bmem_rdata_i,
    input  logic   bmem_rvalid_i,
    input  logic   redirect_i,
    input  addr_t  redirect_pc_i,
    input  logic   dequeue_i,
    output logic   inst_valid_o,
    output inst_t  inst_o,
    output addr_t  pc_o,
    output order_t order_o
);

    addr_t     fetch_pc;
    logic      hit;
    inst_t     word;
    logic      fill_req;
    line_tag_t fill_addr;
    logic      fill_done;
    line_t     fill_line;
    logic      invalidate;
    logic      enq;
    inst_t     enq_inst;
    addr_t     enq_pc;
    order_t    enq_order;
    logic      full;

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .rst          (rst),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .hit_i        (hit),
        .word_i       (word),
        .fill_done_i  (fill_done),
        .full_i       (full),
        .pc_o         (fetch_pc),
        .fill_req_o   (fill_req),
        .fill_addr_o  (fill_addr),
        .invalidate_o (invalidate),
        .enq_o        (enq),
        .enq_inst_o   (enq_inst),
        .enq_pc_o     (enq_pc),
        .enq_order_o  (enq_order)
    );

    // tag comes from the address the burst actually read
    line_buffer u_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .load_i      (fill_done),
        .load_tag_i  (bmem_addr_o[31:5]),
        .load_line_i (fill_line),
        .invalidate_i(invalidate),
        .pc_i        (fetch_pc),
        .hit_o       (hit),
        .word_o      (word)
    );

    burst_assembler u_burst_assembler (
        .clk          (clk),
        .rst          (rst),
        .fill_req_i   (fill_req),
        .fill_addr_i  (fill_addr),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .fill_done_o  (fill_done),
        .fill_line_o  (fill_line)
    );

    inst_queue u_inst_queue (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (redirect_i),
        .enq_i      (enq),
        .enq_inst_i (enq_inst),
        .enq_pc_i   (enq_pc),
        .enq_order_i(enq_order),
        .deq_i      (dequeue_i),
        .full_o     (full),
        .valid_o    (inst_valid_o),
        .inst_o     (inst_o),
        .pc_o       (pc_o),
        .order_o    (order_o)
    );

endmodule

/* tb_fetch_frontend.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module tb_fetch_frontend
import fetch_pkg::*;
;

    localparam int TIMEOUT = 200;

    logic   clk = 1'b0;
    logic   rst;
    addr_t  bmem_addr;
    logic   bmem_read;
    beat_t  bmem_rdata;
    logic   bmem_rvalid;
    logic   redirect;
    addr_t  redirect_pc;
    logic   dequeue;
    logic   inst_valid;
    inst_t  inst;
    addr_t  pc;
    order_t order;

    int          value_errs = 0;
    int          proto_errs = 0;
    int          timeouts = 0;
    int          checked_cnt = 0;
    string       cur_test = "reset";
    logic [15:0] stim_lfsr = 16'd63;
    logic [15:0] mem_lfsr = 16'd63;

    // scoreboard state
    addr_t  exp_pc;
    order_t exp_order;
    order_t issued_cnt;

    // bus monitor state
    logic  read_prev;
    int    beats_left;
    addr_t next_fetch_pc;

    fetch_frontend DUT (
        .clk          (clk),
        .rst          (rst),
        .bmem_addr_o  (bmem_addr),
        .bmem_read_o  (bmem_read),
        .bmem_rdata_i (bmem_rdata),
        .bmem_rvalid_i(bmem_rvalid),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .dequeue_i    (dequeue),
        .inst_valid_o (inst_valid),
        .inst_o       (inst),
        .pc_o         (pc),
        .order_o      (order)
    );

    always #2 clk = ~clk;

    // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    task automatic take_bits(inout logic [15:0] s, input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(s[0]);
            s = lfsr_step(s);
        end
    endtask

    // memory contents as a hash of the word address
    function automatic inst_t mem_word(input addr_t a);
        logic [31:0] w;
        w = {2'b00, a[31:2]};
        mem_word = (w * 32'h9e3779b1) ^ w;
    endfunction

    task automatic check_inst(input string test, input inst_t exp, input inst_t act);
        if (exp !== act) begin
            value_errs++;
            $display("error %s: inst expected %h, actual %h", test, exp, act);
        end
    endtask

    task automatic check_addr(input string test, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            value_errs++;
            $display("error %s: address expected %h, actual %h", test, exp, act);
        end
    endtask

    task automatic check_order(input string test, input order_t exp, input order_t act);
        if (exp !== act) begin
            value_errs++;
            $display("error %s: order expected %0d, actual %0d", test, exp, act);
        end
    endtask

    // memory model with one burst per read pulse
    initial begin
        int    wait_n;
        addr_t line_addr;
        bmem_rvalid = 1'b0;
        bmem_rdata  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && bmem_read) begin
                line_addr = bmem_addr;
                take_bits(mem_lfsr, 3, wait_n);
                wait_n = wait_n + 1;
                for (int k = 0; k < `BEATS_PER_LINE; k++) begin
                    if (wait_n > 0) begin
                        repeat (wait_n) @(posedge clk);
                        #1;
                    end
                    bmem_rvalid = 1'b1;
                    bmem_rdata  = {mem_word(line_addr + 8 * k + 4), mem_word(line_addr + 8 * k)};
                    @(posedge clk);
                    #1;
                    bmem_rvalid = 1'b0;
                    take_bits(mem_lfsr, 2, wait_n);
                end
            end
        end
    end

    // bus monitor sampled away from the drive edge
    always @(negedge clk) begin
        if (rst) begin
            read_prev     = 1'b0;
            beats_left    = 0;
            next_fetch_pc = `FETCH_RESET_PC;
        end else begin
            if (bmem_read) begin
                if (read_prev) begin
                    proto_errs++;
                    $display("memory read pulse lasted more than one cycle in %s", cur_test);
                end
                if (beats_left != 0) begin
                    proto_errs++;
                    $display("new memory read issued before the previous burst ended");
                end
                check_addr(cur_test, {next_fetch_pc[31:5], 5'b00000}, bmem_addr);
                beats_left = `BEATS_PER_LINE;
            end
            if (bmem_rvalid) begin
                beats_left--;
            end
            read_prev = bmem_read;
            // fetch address steps by one word per enqueue and jumps on redirect
            if (redirect) begin
                next_fetch_pc = redirect_pc;
            end else if (DUT.enq) begin
                next_fetch_pc = next_fetch_pc + 32'd4;
            end
        end
    end

    // compares each dequeued head with the expected stream
    always @(negedge clk) begin
        if (rst) begin
            exp_pc     = `FETCH_RESET_PC;
            exp_order  = '0;
            issued_cnt = '0;
        end else if (redirect) begin
            // order continues past entries that the flush drops
            exp_pc    = redirect_pc;
            exp_order = issued_cnt;
        end else begin
            if (dequeue && inst_valid) begin
                check_addr(cur_test, exp_pc, pc);
                check_inst(cur_test, mem_word(exp_pc), inst);
                check_order(cur_test, exp_order, order);
                exp_pc    = exp_pc + 32'd4;
                exp_order = exp_order + 64'd1;
                checked_cnt++;
            end
            if (DUT.enq) begin
                issued_cnt = issued_cnt + 64'd1;
            end
        end
    end

    task automatic drain(input string name, input int n);
        int got;
        int idle;
        got = 0;
        idle = 0;
        cur_test = name;
        while (got < n && idle < TIMEOUT) begin
            @(posedge clk);
            #1;
            if (inst_valid) begin
                dequeue = 1'b1;
                got++;
                idle = 0;
            end else begin
                dequeue = 1'b0;
                idle++;
            end
        end
        @(posedge clk);
        #1;
        dequeue = 1'b0;
        if (got < n) begin
            timeouts++;
            $display("timeout in %s: only %0d of %0d instructions arrived", name, got, n);
        end
    endtask

    task automatic wait_full(input string name);
        int n;
        n = 0;
        cur_test = name;
        @(posedge clk);
        #1;
        while (!DUT.full && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!DUT.full) begin
            timeouts++;
            $display("timeout in %s: instruction queue never became full", name);
        end
    endtask

    task automatic wait_read(input string name);
        int n;
        n = 0;
        cur_test = name;
        @(posedge clk);
        #1;
        while (!bmem_read && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!bmem_read) begin
            timeouts++;
            $display("timeout in %s: no memory read was issued", name);
        end
    endtask

    task automatic redirect_to(input string name);
        int r;
        take_bits(stim_lfsr, 16, r);
        cur_test = name;
        @(posedge clk);
        #1;
        dequeue     = 1'b0;
        redirect    = 1'b1;
        redirect_pc = 32'h8000_0000 | (addr_t'(r) << 2);
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    initial begin
        rst         = 1'b1;
        dequeue     = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // sequential stream across several lines
        drain("sequential", 40);

        // let the queue fill, hold, then drain back to back
        wait_full("backpressure");
        repeat (8) @(posedge clk);
        drain("backpressure", `IQ_DEPTH + 8);

        drain("pre_redirect", 5);
        redirect_to("redirect");
        drain("redirect", 20);

        // second redirect lands while the first fill is in flight
        for (int i = 0; i < 3; i++) begin
            redirect_to("redirect_fill");
            wait_read("redirect_fill");
            redirect_to("redirect_fill");
            drain("redirect_fill", 12);
        end

        repeat (4) @(posedge clk);
        $display("summary: %0d value errors, %0d protocol errors, %0d timeouts, %0d compared",
                 value_errs, proto_errs, timeouts, checked_cnt);
        if (value_errs + proto_errs + timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
fetch_pkg.sv
burst_assembler.sv
line_buffer.sv
inst_queue.sv
fetch_ctrl.sv
fetch_frontend.sv
tb_fetch_frontend.sv
